//--- rtl/lenet_pkg.sv
package lenet_pkg;

    localparam int pixel_w     = 8;
    localparam int word_w      = 32;
    localparam int lanes       = 4;
    localparam int addr_w      = 16;
    localparam int acc_w       = 25;
    localparam int scale_w     = 32;
    localparam int kernel      = 5;
    localparam int quant_shift = 16;
    localparam int out_base    = 256;

    typedef logic signed [pixel_w-1:0] pixel_t;
    typedef logic signed [acc_w-1:0]   acc_t;

    // lane 0 sits in the low byte
    typedef union packed {
        logic [word_w-1:0]    word;
        pixel_t [lanes-1:0]   lane;
    } act_word_u;

endpackage

//--- rtl/pe.sv
`timescale 1ns/1ps

module pe
    import lenet_pkg::*;
(
    input  logic                clk,
    input  logic                rst_n,
    input  logic                mac_en,
    input  logic                acc_clr,
    input  pixel_t [kernel-1:0] pixel,
    input  pixel_t [kernel-1:0] weight,
    output acc_t                acc
);
    logic signed [2*pixel_w-1:0] prod [kernel];
    logic mac_en_d;
    acc_t prod_sum;

    always_ff @(posedge clk) begin
        for (int i = 0; i < kernel; i++) begin
            prod[i] <= pixel[i] * weight[i];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mac_en_d <= 1'b0;
        end else begin
            mac_en_d <= mac_en;
        end
    end

    always_comb begin
        prod_sum = '0;
        for (int i = 0; i < kernel; i++) begin
            prod_sum = prod_sum + acc_t'(prod[i]);
        end
    end

    always_ff @(posedge clk) begin
        if (acc_clr) begin
            acc <= '0;
        end else if (mac_en_d) begin
            acc <= acc + prod_sum;
        end
    end

endmodule

//--- rtl/pe_array.sv
`timescale 1ns/1ps

module pe_array
    import lenet_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic [word_w-1:0] act_rdata0,
    input  logic [word_w-1:0] act_rdata1,
    input  logic [word_w-1:0] weight_rdata0,
    input  logic [word_w-1:0] weight_rdata1,
    input  logic              mac_en0,
    input  logic              mac_en1,
    input  logic              acc_clr,
    output acc_t              psum [0:7]
);
    localparam int cols = 4;

    act_word_u act_q0;
    act_word_u act_q1;
    act_word_u wgt_q0;
    act_word_u wgt_q1;
    pixel_t [2*lanes-1:0] window;
    pixel_t [kernel-1:0]  wgt_top;
    pixel_t [kernel-1:0]  wgt_bot;

    always_ff @(posedge clk) begin
        act_q0.word <= act_rdata0;
        act_q1.word <= act_rdata1;
        wgt_q0.word <= weight_rdata0;
        wgt_q1.word <= weight_rdata1;
    end

    // eight pixel window, leftmost pixel in element 0
    assign window  = {act_q1.lane, act_q0.lane};
    assign wgt_top = {wgt_q1.lane[0], wgt_q0.lane};

    // bottom row runs one kernel row behind
    always_ff @(posedge clk) begin
        wgt_bot <= wgt_top;
    end

    for (genvar k = 0; k < cols; k++) begin : g_col
        pe u_pe_top (
            .clk    (clk),
            .rst_n  (rst_n),
            .mac_en (mac_en0),
            .acc_clr(acc_clr),
            .pixel  (window[k +: kernel]),
            .weight (wgt_top),
            .acc    (psum[k])
        );

        pe u_pe_bot (
            .clk    (clk),
            .rst_n  (rst_n),
            .mac_en (mac_en1),
            .acc_clr(acc_clr),
            .pixel  (window[k +: kernel]),
            .weight (wgt_bot),
            .acc    (psum[cols + k])
        );
    end

endmodule

//--- rtl/pool_quant.sv
`timescale 1ns/1ps

module pool_quant
    import lenet_pkg::*;
(
    input  logic               clk,
    input  logic               rst_n,
    input  logic [scale_w-1:0] scale,
    input  acc_t               psum [0:7],
    input  logic               pool_valid,
    input  logic               lane_hi,
    output logic [word_w-1:0]  act_wdata0
);
    acc_t max_q [0:1];
    logic signed [scale_w-1:0] scale_q;
    logic hi_q;
    logic quant_en;
    act_word_u out_q;

    function automatic acc_t max4(acc_t a, acc_t b, acc_t c, acc_t d);
        acc_t ab;
        acc_t cd;
        ab = (a > b) ? a : b;
        cd = (c > d) ? c : d;
        return (ab > cd) ? ab : cd;
    endfunction

    // scale, shift, saturate, then relu
    function automatic pixel_t quant(acc_t m, logic signed [scale_w-1:0] s);
        logic signed [scale_w+acc_w-1:0] prod;
        logic signed [scale_w+acc_w-1:0] shifted;
        prod    = s * m;
        shifted = prod >>> quant_shift;
        if (m <= 0) begin
            return '0;
        end else if (shifted > 127) begin
            return 8'sd127;
        end else if (shifted < -128) begin
            return -8'sd128;
        end
        return pixel_t'(shifted[pixel_w-1:0]);
    endfunction

    // quads are {top 0, top 1, bottom 0, bottom 1} and the pair to the right
    always_ff @(posedge clk) begin
        if (pool_valid) begin
            max_q[0] <= max4(psum[0], psum[1], psum[4], psum[5]);
            max_q[1] <= max4(psum[2], psum[3], psum[6], psum[7]);
            scale_q  <= scale;
            hi_q     <= lane_hi;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            quant_en <= 1'b0;
        end else begin
            quant_en <= pool_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (quant_en) begin
            out_q.lane[{hi_q, 1'b0}] <= quant(max_q[0], scale_q);
            out_q.lane[{hi_q, 1'b1}] <= quant(max_q[1], scale_q);
        end
    end

    assign act_wdata0 = out_q.word;

    a_lane_known: assert property (@(posedge clk) disable iff (!rst_n)
        pool_valid |-> !$isunknown(lane_hi));

endmodule

//--- rtl/conv_ctrl.sv
`timescale 1ns/1ps

module conv_ctrl
    import lenet_pkg::*;
#(
    parameter int IMG_SIZE = 12,
    parameter int OUT_CH   = 2
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              compute_start,
    output logic [addr_w-1:0] act_addr0,
    output logic [addr_w-1:0] act_addr1,
    output logic [addr_w-1:0] weight_addr0,
    output logic [addr_w-1:0] weight_addr1,
    output logic [lanes-1:0]  act_wea0,
    output logic              mac_en0,
    output logic              mac_en1,
    output logic              acc_clr,
    output logic              pool_valid,
    output logic              lane_hi,
    output logic              compute_finish
);
    localparam int prows     = (IMG_SIZE - 4) / 2;
    localparam int groups    = (IMG_SIZE - 4) / 4;
    localparam int row_words = IMG_SIZE / lanes;
    localparam int out_words = (IMG_SIZE - 4) / 8;
    localparam int reads     = kernel + 1;
    localparam int drain_len = 3;

    localparam logic [2:0] st_idle   = 3'd0;
    localparam logic [2:0] st_read   = 3'd1;
    localparam logic [2:0] st_drain  = 3'd2;
    localparam logic [2:0] st_pool   = 3'd3;
    localparam logic [2:0] st_write  = 3'd4;
    localparam logic [2:0] st_finish = 3'd5;

    logic [2:0] state;
    logic [2:0] step;
    logic [2:0] wrow;
    logic [$clog2(OUT_CH+1)-1:0] ch;
    logic [$clog2(prows+1)-1:0]  prow;
    logic [$clog2(groups+1)-1:0] grp;
    logic last_grp;
    logic last_group;
    logic rd_d1;
    logic rd_d2;
    logic [2:0] step_d1;
    logic [2:0] step_d2;
    logic [addr_w-1:0] rd_addr;
    logic [addr_w-1:0] out_addr;
    logic [addr_w-1:0] w_addr;

    assign last_grp   = int'(grp) == groups - 1;
    assign last_group = last_grp && int'(prow) == prows - 1 && int'(ch) == OUT_CH - 1;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= st_idle;
            step  <= '0;
            ch    <= '0;
            prow  <= '0;
            grp   <= '0;
        end else begin
            case (state)
                st_idle: begin
                    step <= '0;
                    ch   <= '0;
                    prow <= '0;
                    grp  <= '0;
                    if (compute_start) begin
                        state <= st_read;
                    end
                end
                st_read: begin
                    if (int'(step) == reads - 1) begin
                        step  <= '0;
                        state <= st_drain;
                    end else begin
                        step <= step + 1'b1;
                    end
                end
                st_drain: begin
                    if (int'(step) == drain_len - 1) begin
                        step  <= '0;
                        state <= st_pool;
                    end else begin
                        step <= step + 1'b1;
                    end
                end
                st_pool: begin
                    // even groups only fill the low lane pair
                    if (grp[0]) begin
                        state <= st_write;
                    end else begin
                        grp   <= grp + 1'b1;
                        state <= st_read;
                    end
                end
                st_write: begin
                    if (step == 3'd1) begin
                        step <= '0;
                        if (last_group) begin
                            state <= st_finish;
                        end else begin
                            state <= st_read;
                            if (!last_grp) begin
                                grp <= grp + 1'b1;
                            end else begin
                                grp <= '0;
                                if (int'(prow) != prows - 1) begin
                                    prow <= prow + 1'b1;
                                end else begin
                                    prow <= '0;
                                    ch   <= ch + 1'b1;
                                end
                            end
                        end
                    end else begin
                        step <= step + 1'b1;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // read data reaches the pe inputs two cycles after its address
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_d1 <= 1'b0;
            rd_d2 <= 1'b0;
        end else begin
            rd_d1 <= state == st_read;
            rd_d2 <= rd_d1;
        end
    end

    always_ff @(posedge clk) begin
        step_d1 <= step;
        step_d2 <= step_d1;
    end

    assign wrow = (int'(step) < kernel) ? step : 3'(kernel - 1);

    always_comb begin
        rd_addr  = addr_w'((2 * int'(prow) + int'(step)) * row_words + int'(grp));
        out_addr = addr_w'(out_base + (int'(ch) * prows + int'(prow)) * out_words
                           + int'(grp) / 2);
        w_addr   = addr_w'((int'(ch) * kernel + int'(wrow)) * 2);
    end

    assign act_addr0      = (state == st_write) ? out_addr : rd_addr;
    assign act_addr1      = rd_addr + 1'b1;
    assign weight_addr0   = w_addr;
    assign weight_addr1   = w_addr + 1'b1;
    assign act_wea0       = {lanes{state == st_write && step == 3'd1}};
    assign mac_en0        = rd_d2 && int'(step_d2) < kernel;
    assign mac_en1        = rd_d2 && step_d2 != 3'd0;
    assign acc_clr        = state == st_read && step == 3'd0;
    assign pool_valid     = state == st_pool;
    assign lane_hi        = grp[0];
    assign compute_finish = state == st_finish;

    a_weight_range: assert property (@(posedge clk) disable iff (!rst_n)
        int'(weight_addr1) < OUT_CH * 2 * kernel);

    // no output write while a group is still being read or accumulated
    a_no_write_in_read: assert property (@(posedge clk) disable iff (!rst_n)
        (rd_d1 || rd_d2) |-> act_wea0 == '0);

endmodule

//--- rtl/lenet_conv1.sv
`timescale 1ns/1ps

module lenet_conv1
    import lenet_pkg::*;
#(
    parameter int IMG_SIZE = 12,
    parameter int OUT_CH   = 2
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               compute_start,
    input  logic [scale_w-1:0] scale,
    output logic               compute_finish,
    output logic [addr_w-1:0]  act_addr0,
    output logic [addr_w-1:0]  act_addr1,
    output logic [lanes-1:0]   act_wea0,
    output logic [word_w-1:0]  act_wdata0,
    input  logic [word_w-1:0]  act_rdata0,
    input  logic [word_w-1:0]  act_rdata1,
    output logic [addr_w-1:0]  weight_addr0,
    output logic [addr_w-1:0]  weight_addr1,
    input  logic [word_w-1:0]  weight_rdata0,
    input  logic [word_w-1:0]  weight_rdata1
);
    logic mac_en0;
    logic mac_en1;
    logic acc_clr;
    logic pool_valid;
    logic lane_hi;
    acc_t psum [0:7];

    conv_ctrl #(
        .IMG_SIZE(IMG_SIZE),
        .OUT_CH  (OUT_CH)
    ) u_ctrl (.*);

    pe_array u_pe_array (.*);

    pool_quant u_pool_quant (.*);

endmodule

//--- bench/tb_lenet_conv1.sv
`timescale 1ns/1ps

module tb_lenet_conv1
    import lenet_pkg::*;
;
    localparam int IMG_SIZE       = 12;
    localparam int OUT_CH         = 2;
    localparam int prows          = (IMG_SIZE - 4) / 2;
    localparam int groups_per_row = (IMG_SIZE - 4) / 4;
    localparam int groups_per_run = OUT_CH * prows * groups_per_row;
    localparam int total_writes   = OUT_CH * prows * prows / lanes;
    localparam int image_words    = IMG_SIZE * IMG_SIZE / lanes;
    localparam int kernel_words   = OUT_CH * kernel * 2;
    localparam int data_words     = 1 + image_words + kernel_words + total_writes;
    localparam int timeout_cycles = 200 * groups_per_run * 2;

    logic               clk;
    logic               rst_n;
    logic               compute_start;
    logic [scale_w-1:0] scale;
    logic               compute_finish;
    logic [addr_w-1:0]  act_addr0;
    logic [addr_w-1:0]  act_addr1;
    logic [lanes-1:0]   act_wea0;
    logic [word_w-1:0]  act_wdata0;
    logic [word_w-1:0]  act_rdata0;
    logic [word_w-1:0]  act_rdata1;
    logic [addr_w-1:0]  weight_addr0;
    logic [addr_w-1:0]  weight_addr1;
    logic [word_w-1:0]  weight_rdata0;
    logic [word_w-1:0]  weight_rdata1;

    logic [word_w-1:0] tdata [0:data_words-1];
    logic [word_w-1:0] act_mem [0:1023];
    logic [word_w-1:0] weight_mem [0:63];

    int  cycle;
    int  wr_count;
    int  last_wr_cycle;
    bit  running;
    bit  finish_seen;

    lenet_conv1 #(
        .IMG_SIZE(IMG_SIZE),
        .OUT_CH  (OUT_CH)
    ) dut0 (
        .clk           (clk),
        .rst_n         (rst_n),
        .compute_start (compute_start),
        .scale         (scale),
        .compute_finish(compute_finish),
        .act_addr0     (act_addr0),
        .act_addr1     (act_addr1),
        .act_wea0      (act_wea0),
        .act_wdata0    (act_wdata0),
        .act_rdata0    (act_rdata0),
        .act_rdata1    (act_rdata1),
        .weight_addr0  (weight_addr0),
        .weight_addr1  (weight_addr1),
        .weight_rdata0 (weight_rdata0),
        .weight_rdata1 (weight_rdata1)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    task automatic check_value(string name, logic [31:0] actual, logic [31:0] expected);
        if (actual !== expected) begin
            $display("Error: %s is %h, expected %h", name, actual, expected);
            $display("Errors found");
            $fatal(1);
        end
    endtask

    task automatic report_failure(string what);
        $display("%s", what);
        $display("Errors found");
        $fatal(1);
    endtask

    // one-cycle read srams, byte write enables on port 0
    always @(posedge clk) begin
        act_rdata0    <= act_mem[act_addr0[9:0]];
        act_rdata1    <= act_mem[act_addr1[9:0]];
        weight_rdata0 <= weight_mem[weight_addr0[5:0]];
        weight_rdata1 <= weight_mem[weight_addr1[5:0]];
        for (int b = 0; b < lanes; b++) begin
            if (act_wea0[b]) begin
                act_mem[act_addr0[9:0]][8*b +: 8] <= act_wdata0[8*b +: 8];
            end
        end
    end

    // outputs are stable at the falling edge
    always @(negedge clk) begin
        if (act_wea0 != '0) begin
            if (!running) begin
                report_failure("act_wea0 was raised outside a run");
            end
            if (wr_count >= total_writes) begin
                report_failure("more output writes than expected in one run");
            end
            check_value("act_wea0", 32'(act_wea0), 32'h0000000f);
            check_value("act_addr0", 32'(act_addr0), 32'(out_base + wr_count));
            check_value("act_wdata0", act_wdata0,
                        tdata[1 + image_words + kernel_words + wr_count]);
            wr_count      = wr_count + 1;
            last_wr_cycle = cycle;
        end
        if (compute_finish) begin
            if (!running || finish_seen) begin
                report_failure("compute_finish was high outside the end of a run");
            end
            check_value("write count", 32'(wr_count), 32'(total_writes));
            check_value("cycles from last write to finish", 32'(cycle - last_wr_cycle), 32'd1);
            finish_seen = 1'b1;
        end
    end

    initial begin
        repeat (timeout_cycles) @(posedge clk);
        $display("Timed out: compute_finish did not arrive in time");
        $display("Errors found");
        $fatal(1);
    end

    initial begin
        int seed;
        int gap;
        rst_n         = 1'b0;
        compute_start = 1'b0;
        scale         = '0;
        act_rdata0    <= '0;
        act_rdata1    <= '0;
        weight_rdata0 <= '0;
        weight_rdata1 <= '0;
        cycle         = 0;
        wr_count      = 0;
        last_wr_cycle = 0;
        running       = 1'b0;
        finish_seen   = 1'b0;
        seed = $urandom(32'hd5197ec1);

        $readmemh("bench/lenet_conv1_testdata.hex", tdata);
        for (int i = 0; i < 1024; i++) begin
            act_mem[i] = 32'(i) * 32'h9e3779b1;
        end
        for (int i = 0; i < 64; i++) begin
            weight_mem[i] = 32'(i) * 32'h85ebca6b + 32'h0000beef;
        end
        for (int i = 0; i < image_words; i++) begin
            act_mem[i] = tdata[1 + i];
        end
        for (int i = 0; i < kernel_words; i++) begin
            weight_mem[i] = tdata[1 + image_words + i];
        end

        repeat (16) @(posedge clk);
        rst_n <= 1'b1;

        for (int run = 0; run < 2; run++) begin
            gap = int'($urandom % 16) + 2;
            repeat (gap) @(posedge clk);
            running       = 1'b1;
            finish_seen   = 1'b0;
            wr_count      = 0;
            compute_start <= 1'b1;
            scale         <= tdata[0];
            @(posedge clk);
            compute_start <= 1'b0;
            wait (finish_seen);
            // a second finish cycle now counts as outside the run
            running = 1'b0;
        end

        repeat (4) @(posedge clk);
        $display("No errors");
        $finish;
    end

endmodule

//--- bench/lenet_conv1_testdata.hex
// word 0 scale, then 36 image words, 20 kernel words, 8 expected outputs
// every word holds lane 0 in its low byte
00040000
DBDAD9D8
DFDEDDDC
E3E2E1E0
E5E4E3E2
E9E8E7E6
EDECEBEA
EFEEEDEC
F3F2F1F0
F7F6F5F4
F9F8F7F6
FDFCFBFA
0100FFFE
03020100
07060504
0B0A0908
0D0C0B0A
11100F0E
15141312
17161514
1B1A1918
1F1E1D1C
21201F1E
25242322
29282726
2B2A2928
2F2E2D2C
33323130
35343332
39383736
3D3C3B3A
3F3E3D3C
43424140
47464544
49484746
4D4C4B4A
51504F4E
00000001
00000000
00000000
00000000
00000000
00000000
00000000
00000000
00000000
00000000
00000000
00000000
00030000
00000000
00000000
00000000
00000000
00000000
00000000
000000FF
00000000
00000000
443C342C
7F7F7F7C
00000000
00000000
68584838
7F7F7F7F

//--- src.f
rtl/lenet_pkg.sv
rtl/pe.sv
rtl/pe_array.sv
rtl/pool_quant.sv
rtl/conv_ctrl.sv
rtl/lenet_conv1.sv
bench/tb_lenet_conv1.sv

//--- run_sim.sh
#!/bin/sh
set -e

rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_lenet_conv1 -f src.f --Mdir obj_dir -o sim_tb

./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "Errors found" sim.log; then
    exit 1
fi
grep -q "No errors" sim.log
